// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    // One state per cycle of the multicycle sequence
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_B    = 3'd1,
        BR_BL   = 3'd2,
        BR_BEQ  = 3'd3,
        BR_BNE  = 3'd4,
        BR_JIRL = 3'd5
    } br_kind_t;

    typedef struct packed {
        alu_op_t     alu_op;
        br_kind_t    br_kind;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        res_from_mem;
        logic        gr_we;
        logic        mem_rd;
        logic        mem_we;
        logic [4:0]  dest;
        logic [31:0] imm;
        logic [31:0] br_offs;
        logic        illegal;
    } decode_t;

endpackage

// ==== source/cpu_control.sv ====
`timescale 1ns/100ps

module cpu_control import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  decode_t dec,
    output state_t  state,
    output logic    ir_load,
    output logic    alu_load,
    output logic    rf_we,
    output logic    pc_update,
    output logic    data_sram_we
);

    state_t state_next;
    logic   ends_in_execute;
    logic   mem_access;

    // b, beq, bne and illegal words retire right after EXECUTE
    assign mem_access      = dec.mem_rd || dec.mem_we;
    assign ends_in_execute = (dec.br_kind inside {BR_B, BR_BEQ, BR_BNE})
                             || !(dec.gr_we || mem_access);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH:     state_next = DECODE;
            DECODE:    state_next = EXECUTE;
            EXECUTE: begin
                if (ends_in_execute) begin
                    state_next = FETCH;
                end else if (mem_access) begin
                    state_next = MEMORY;
                end else begin
                    state_next = WRITEBACK;
                end
            end
            MEMORY: begin
                if (dec.mem_rd) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = FETCH;
                end
            end
            WRITEBACK: state_next = FETCH;
            default:   state_next = FETCH;
        endcase
    end

    assign ir_load      = (state == DECODE);
    assign alu_load     = (state == EXECUTE);
    assign rf_we        = (state == WRITEBACK);
    assign data_sram_we = (state == MEMORY) && dec.mem_we;
    assign pc_update    = ((state == EXECUTE) && ends_in_execute)
                          || ((state == MEMORY) && dec.mem_we)
                          || (state == WRITEBACK);

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && (state inside {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK}));

    // A store writes no register
    a_store_in_memory: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> (state == MEMORY) && !dec.gr_we && !dec.mem_rd);

    a_write_in_writeback: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> (state == WRITEBACK) && dec.gr_we);

    // Illegal words retire as no-ops
    a_illegal_retires: assert property (@(posedge clk) disable iff (reset)
        (state == EXECUTE) && dec.illegal |-> pc_update);

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        ir_load,
    input  logic [31:0] inst,
    output decode_t     dec,
    output logic [4:0]  raddr1,
    output logic [4:0]  raddr2
);

    // addi.w r0, r0, 0
    localparam logic [31:0] NOP = 32'h0280_0000;

    logic [31:0] ir;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic        three_reg;
    logic        shift_imm;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_lu12i_w;
    logic inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= NOP;
        end else if (ir_load) begin
            ir <= inst;
        end
    end

    assign op_31_26 = ir[31:26];
    assign op_25_22 = ir[25:22];
    assign op_21_20 = ir[21:20];
    assign op_19_15 = ir[19:15];
    assign rd       = ir[4:0];
    assign rj       = ir[9:5];
    assign rk       = ir[14:10];

    assign three_reg = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign shift_imm = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = three_reg && (op_19_15 == 5'h00);
    assign inst_sub_w   = three_reg && (op_19_15 == 5'h02);
    assign inst_slt     = three_reg && (op_19_15 == 5'h04);
    assign inst_sltu    = three_reg && (op_19_15 == 5'h05);
    assign inst_nor     = three_reg && (op_19_15 == 5'h08);
    assign inst_and     = three_reg && (op_19_15 == 5'h09);
    assign inst_or      = three_reg && (op_19_15 == 5'h0a);
    assign inst_xor     = three_reg && (op_19_15 == 5'h0b);
    assign inst_slli_w  = shift_imm && (op_19_15 == 5'h01);
    assign inst_srli_w  = shift_imm && (op_19_15 == 5'h09);
    assign inst_srai_w  = shift_imm && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !ir[25];
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);

    always_comb begin
        dec = '0;

        // Loads, stores and links all add
        dec.alu_op = ALU_ADD;
        if (inst_sub_w)   dec.alu_op = ALU_SUB;
        if (inst_slt)     dec.alu_op = ALU_SLT;
        if (inst_sltu)    dec.alu_op = ALU_SLTU;
        if (inst_and)     dec.alu_op = ALU_AND;
        if (inst_nor)     dec.alu_op = ALU_NOR;
        if (inst_or)      dec.alu_op = ALU_OR;
        if (inst_xor)     dec.alu_op = ALU_XOR;
        if (inst_slli_w)  dec.alu_op = ALU_SLL;
        if (inst_srli_w)  dec.alu_op = ALU_SRL;
        if (inst_srai_w)  dec.alu_op = ALU_SRA;
        if (inst_lu12i_w) dec.alu_op = ALU_LUI;

        dec.br_kind = BR_NONE;
        if (inst_b)    dec.br_kind = BR_B;
        if (inst_bl)   dec.br_kind = BR_BL;
        if (inst_beq)  dec.br_kind = BR_BEQ;
        if (inst_bne)  dec.br_kind = BR_BNE;
        if (inst_jirl) dec.br_kind = BR_JIRL;

        // Immediate for source 2
        if (inst_jirl || inst_bl) begin
            dec.imm = 32'd4;
        end else if (inst_lu12i_w) begin
            dec.imm = {ir[24:5], 12'b0};
        end else if (inst_slli_w || inst_srli_w || inst_srai_w) begin
            dec.imm = {27'b0, ir[14:10]};
        end else begin
            dec.imm = {{20{ir[21]}}, ir[21:10]};
        end

        if (inst_b || inst_bl) begin
            dec.br_offs = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b0};
        end else begin
            dec.br_offs = {{14{ir[25]}}, ir[25:10], 2'b0};
        end

        dec.src1_is_pc   = inst_jirl || inst_bl;
        dec.src2_is_imm  = inst_slli_w || inst_srli_w || inst_srai_w || inst_addi_w
                           || inst_lu12i_w || inst_ld_w || inst_st_w || inst_jirl || inst_bl;
        dec.res_from_mem = inst_ld_w;
        dec.mem_rd       = inst_ld_w;
        dec.mem_we       = inst_st_w;
        dec.gr_we        = three_reg && (inst_add_w || inst_sub_w || inst_slt || inst_sltu
                           || inst_nor || inst_and || inst_or || inst_xor);
        dec.gr_we        = dec.gr_we || inst_slli_w || inst_srli_w || inst_srai_w
                           || inst_addi_w || inst_lu12i_w || inst_ld_w || inst_jirl || inst_bl;
        dec.dest         = inst_bl ? 5'd1 : rd;
        dec.illegal      = !(dec.gr_we || inst_st_w || inst_b || inst_beq || inst_bne);
    end

    assign raddr1 = rj;
    assign raddr2 = (inst_beq || inst_bne || inst_st_w) ? rd : rk;

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic        res_from_mem,
    input  logic [31:0] alu_result,
    input  logic [31:0] mem_rdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    output logic [31:0] wdata
);

    logic [31:0] regs [32];

    // Loaded word or ALU result
    assign wdata = res_from_mem ? mem_rdata : alu_result;

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

    a_waddr_known: assert property (@(posedge clk)
        we |-> !$isunknown(waddr));

endmodule

// ==== source/alu.sv ====
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        alu_load,
    input  decode_t     dec,
    input  logic [31:0] pc,
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    output logic [31:0] result
);

    logic [31:0] src1;
    logic [31:0] src2;
    logic [4:0]  shamt;
    logic [31:0] alu_out;

    assign src1  = dec.src1_is_pc ? pc : rdata1;
    assign src2  = dec.src2_is_imm ? dec.imm : rdata2;
    assign shamt = src2[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_out = src1 + src2;
            ALU_SUB:  alu_out = src1 - src2;
            ALU_SLT:  alu_out = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: alu_out = {31'b0, src1 < src2};
            ALU_AND:  alu_out = src1 & src2;
            ALU_NOR:  alu_out = ~(src1 | src2);
            ALU_OR:   alu_out = src1 | src2;
            ALU_XOR:  alu_out = src1 ^ src2;
            ALU_SLL:  alu_out = src1 << shamt;
            ALU_SRL:  alu_out = src1 >> shamt;
            ALU_SRA:  alu_out = $unsigned($signed(src1) >>> shamt);
            // Immediate is already shifted up by the decoder
            ALU_LUI:  alu_out = src2;
            default:  alu_out = src1 + src2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= 32'b0;
        end else if (alu_load) begin
            result <= alu_out;
        end
    end

endmodule

// ==== source/pc_unit.sv ====
`timescale 1ns/100ps

module pc_unit import cpu_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        pc_update,
    input  decode_t     dec,
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    output logic [31:0] pc
);

    logic        rj_eq_rd;
    logic        taken;
    logic [31:0] target;

    assign rj_eq_rd = (rdata1 == rdata2);
    assign taken    = ((dec.br_kind == BR_BEQ) && rj_eq_rd)
                      || ((dec.br_kind == BR_BNE) && !rj_eq_rd)
                      || (dec.br_kind inside {BR_B, BR_BL, BR_JIRL});

    // jirl is register relative, the rest PC relative
    assign target = (dec.br_kind == BR_JIRL) ? rdata1 + dec.br_offs : pc + dec.br_offs;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_update) begin
            pc <= taken ? target : pc + 32'd4;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc_update |=> (pc[1:0] == 2'b00));

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    decode_t     dec;
    logic        ir_load;
    logic        alu_load;
    logic        rf_we;
    logic        pc_update;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] wdata;
    logic [31:0] alu_result;
    logic [31:0] pc;

    cpu_control u_control (
        .clk          (clk),
        .reset        (reset),
        .dec          (dec),
        .state        (),
        .ir_load      (ir_load),
        .alu_load     (alu_load),
        .rf_we        (rf_we),
        .pc_update    (pc_update),
        .data_sram_we (data_sram_we)
    );

    inst_decoder u_decoder (
        .clk     (clk),
        .reset   (reset),
        .ir_load (ir_load),
        .inst    (inst_sram_rdata),
        .dec     (dec),
        .raddr1  (raddr1),
        .raddr2  (raddr2)
    );

    regfile u_regfile (
        .clk          (clk),
        .we           (rf_we),
        .waddr        (dec.dest),
        .res_from_mem (dec.res_from_mem),
        .alu_result   (alu_result),
        .mem_rdata    (data_sram_rdata),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .wdata        (wdata)
    );

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .alu_load (alu_load),
        .dec      (dec),
        .pc       (pc),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .result   (alu_result)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk       (clk),
        .reset     (reset),
        .pc_update (pc_update),
        .dec       (dec),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .pc        (pc)
    );

    assign inst_sram_addr  = pc;
    assign data_sram_addr  = alu_result;
    // Store data comes from rd through read port 2
    assign data_sram_wdata = rdata2;

    // Trace PC holds the retiring instruction until pc_update takes effect
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dec.dest;
    assign debug_wb_rf_wdata = wdata;

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam logic [31:0] SEED     = 32'hdb73_dd34;
    localparam int          MAX_WAIT = 50;

    // Operands that the first instructions build
    localparam logic [31:0] OP_A    = 32'h0000_05a5;
    localparam logic [31:0] OP_B    = 32'h8000_1234;
    localparam logic [31:0] LUI_VAL = 32'habcd_e000;
    localparam logic [31:0] BASE    = 32'h0000_0100;

    localparam logic [9:0] ADDI = 10'h00a;
    localparam logic [9:0] LD_W = 10'h0a2;
    localparam logic [9:0] ST_W = 10'h0a6;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata = 32'h0;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'h0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] inst_mem [64];
    logic [31:0] data_mem [256];
    logic [31:0] data_init [256];
    logic [5:0]  prog_len = 6'd0;
    trace_row_t  expected [$];
    int          store_count = 0;

    cpu_top #(.RESET_PC(RESET_PC)) u_dut (.*);

    always #50 clk = ~clk;

    // Both memories answer one cycle after the address
    always @(posedge clk) begin
        inst_sram_rdata <= inst_mem[inst_sram_addr[7:2]];
    end

    always @(posedge clk) begin
        if (data_sram_we) begin
            data_mem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
        data_sram_rdata <= data_mem[data_sram_addr[9:2]];
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [4:0] op, rd, rj, rk);
        return {6'h00, 4'h0, 2'h1, op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_shift(input logic [4:0] op, rd, rj, ui5);
        return {6'h00, 4'h1, 2'h0, op, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [4:0] rd, rj,
                                             input logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        return {7'h0a, si20, rd};
    endfunction

    // Offsets are in words
    function automatic logic [31:0] enc_br16(input logic [5:0] op, input logic [4:0] rd, rj,
                                             input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_br26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual, expected_val);
        if (actual !== expected_val) begin
            fail_run($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected_val));
        end
    endtask

    task automatic emit(input logic [31:0] word);
        inst_mem[prog_len] = word;
        prog_len = prog_len + 6'd1;
    endtask

    task automatic expect_write(input logic [31:0] offs, input logic [4:0] wnum,
                                input logic [31:0] value);
        expected.push_back('{pc: RESET_PC + offs, wnum: wnum, wdata: value});
    endtask

    task automatic load_memories();
        logic [31:0] x;
        x = SEED;
        for (int i = 0; i < 256; i++) begin
            x = xorshift(x);
            data_init[i[7:0]] = x;
            data_mem[i[7:0]] = x;
        end
        // Unused words decode as illegal and run as no-ops
        for (int i = 0; i < 64; i++) begin
            inst_mem[i[5:0]] = 32'hfc00_0000 | 32'(i);
        end
    endtask

    task automatic build_program();
        emit(enc_lu12i(5'd5, 20'h80001));
        emit(enc_ri12(ADDI, 5'd5, 5'd5, 12'h234));
        emit(enc_ri12(ADDI, 5'd4, 5'd0, 12'h5a5));
        emit(enc_3r(5'h00, 5'd6, 5'd4, 5'd5));
        emit(enc_3r(5'h02, 5'd7, 5'd4, 5'd5));
        emit(enc_3r(5'h04, 5'd8, 5'd5, 5'd4));
        emit(enc_3r(5'h05, 5'd9, 5'd5, 5'd4));
        emit(enc_3r(5'h08, 5'd10, 5'd4, 5'd5));
        emit(enc_3r(5'h09, 5'd11, 5'd4, 5'd5));
        emit(enc_3r(5'h0a, 5'd12, 5'd4, 5'd5));
        emit(enc_3r(5'h0b, 5'd13, 5'd4, 5'd5));
        emit(enc_shift(5'h01, 5'd14, 5'd5, 5'd4));
        emit(enc_shift(5'h09, 5'd15, 5'd5, 5'd8));
        emit(enc_shift(5'h11, 5'd16, 5'd5, 5'd8));
        emit(enc_lu12i(5'd17, 20'habcde));
        emit(enc_ri12(ADDI, 5'd18, 5'd0, 12'h100));
        emit(enc_ri12(ST_W, 5'd6, 5'd18, 12'h008));
        emit(enc_ri12(LD_W, 5'd19, 5'd18, 12'h008));
        emit(enc_ri12(LD_W, 5'd20, 5'd18, 12'h040));
        // 0x4c: beq r4, r5 not taken
        emit(enc_br16(6'h16, 5'd5, 5'd4, 16'd2));
        emit(enc_ri12(ADDI, 5'd21, 5'd0, 12'h001));
        emit(enc_br16(6'h17, 5'd5, 5'd4, 16'd2));
        emit(enc_ri12(ADDI, 5'd22, 5'd0, 12'h7ff));
        emit(enc_br16(6'h16, 5'd6, 5'd19, 16'd2));
        emit(enc_ri12(ADDI, 5'd22, 5'd0, 12'h7fe));
        emit(enc_br16(6'h17, 5'd19, 5'd6, 16'd2));
        emit(enc_ri12(ADDI, 5'd23, 5'd0, 12'h002));
        emit(enc_br26(6'h14, 26'd2));
        emit(enc_ri12(ADDI, 5'd22, 5'd0, 12'h7fd));
        // 0x74: bl to the jirl, which returns to 0x78
        emit(enc_br26(6'h15, 26'd3));
        emit(enc_ri12(ADDI, 5'd24, 5'd0, 12'h003));
        emit(enc_br26(6'h14, 26'd3));
        emit(enc_br16(6'h13, 5'd25, 5'd1, 16'd0));
        emit(enc_ri12(ADDI, 5'd22, 5'd0, 12'h7fc));
        emit(enc_ri12(ADDI, 5'd0, 5'd0, 12'h055));
        emit(enc_3r(5'h00, 5'd26, 5'd0, 5'd17));
        emit(enc_br26(6'h14, 26'd0));
    endtask

    task automatic build_trace();
        expect_write(32'h00, 5'd5, 32'h8000_1000);
        expect_write(32'h04, 5'd5, OP_B);
        expect_write(32'h08, 5'd4, OP_A);
        expect_write(32'h0c, 5'd6, OP_A + OP_B);
        expect_write(32'h10, 5'd7, OP_A - OP_B);
        // OP_B is negative as signed, large as unsigned
        expect_write(32'h14, 5'd8, 32'd1);
        expect_write(32'h18, 5'd9, 32'd0);
        expect_write(32'h1c, 5'd10, ~(OP_A | OP_B));
        expect_write(32'h20, 5'd11, OP_A & OP_B);
        expect_write(32'h24, 5'd12, OP_A | OP_B);
        expect_write(32'h28, 5'd13, OP_A ^ OP_B);
        expect_write(32'h2c, 5'd14, OP_B << 4);
        expect_write(32'h30, 5'd15, OP_B >> 8);
        expect_write(32'h34, 5'd16, 32'hff80_0012);
        expect_write(32'h38, 5'd17, LUI_VAL);
        expect_write(32'h3c, 5'd18, BASE);
        expect_write(32'h44, 5'd19, OP_A + OP_B);
        expect_write(32'h48, 5'd20, data_init[8'h50]);
        expect_write(32'h50, 5'd21, 32'd1);
        expect_write(32'h68, 5'd23, 32'd2);
        expect_write(32'h74, 5'd1, RESET_PC + 32'h78);
        expect_write(32'h80, 5'd25, RESET_PC + 32'h84);
        expect_write(32'h78, 5'd24, 32'd3);
        expect_write(32'h88, 5'd0, 32'h55);
        expect_write(32'h8c, 5'd26, LUI_VAL);
    endtask

    // The only store of the program
    always @(negedge clk) begin
        if (!reset && data_sram_we) begin
            if (store_count != 0) begin
                fail_run("unexpected second store to the data SRAM");
            end else begin
                check("data_sram_addr", data_sram_addr, BASE + 32'h8);
                check("data_sram_wdata", data_sram_wdata, OP_A + OP_B);
                store_count <= store_count + 1;
            end
        end
    end

    initial begin
        int         waited;
        trace_row_t row;
        reset = 1'b1;
        load_memories();
        build_program();
        build_trace();

        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'h0);
            check("data_sram_we", {31'b0, data_sram_we}, 32'h0);
        end
        check("inst_sram_addr", inst_sram_addr, RESET_PC);
        reset = 1'b0;

        foreach (expected[i]) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (debug_wb_rf_we == 4'h0 && waited < MAX_WAIT);
            if (debug_wb_rf_we == 4'h0) begin
                fail_run($sformatf("timed out waiting for register write number %0d", i));
            end else begin
                row = expected[i];
                check("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'hf);
                check("debug_wb_pc", debug_wb_pc, row.pc);
                check("debug_wb_rf_wnum", {27'b0, debug_wb_rf_wnum}, {27'b0, row.wnum});
                check("debug_wb_rf_wdata", debug_wb_rf_wdata, row.wdata);
            end
        end

        if (store_count != 1) begin
            fail_run("the store never reached the data SRAM");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
source/cpu_pkg.sv
source/cpu_control.sv
source/inst_decoder.sv
source/regfile.sv
source/alu.sv
source/pc_unit.sv
source/cpu_top.sv
tb/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' tb.f)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) tb.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f tb.f --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
